// File: logic/eth_pkg.sv
// Shared types and CRC constants for the Ethernet test frame generator; import where needed

package eth_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Field widths
    ////////////////////////////////////////////////////////////////////////////

    // One octet on the wire
    typedef logic [7:0]  byte_t;

    // Sent most significant byte first
    typedef logic [47:0] mac_addr_t;

    // Type/length field, high byte first
    typedef logic [15:0] ethertype_t;

    // Payload length, 0 to 2047 bytes
    typedef logic [10:0] len_t;

    typedef logic [31:0] crc_t;

    ////////////////////////////////////////////////////////////////////////////
    // Structs
    ////////////////////////////////////////////////////////////////////////////

    // Per-frame configuration, captured at frame start
    typedef struct packed {
        mac_addr_t  dst_mac;
        mac_addr_t  src_mac;
        ethertype_t ethertype;
        byte_t      payload_pattern;
        len_t       payload_length;
    } frame_cfg_t;

    // One sequencer output per cycle
    typedef struct packed {
        byte_t      data;
        logic       valid;
        logic       crc_en;   // byte is part of the CRC
        logic       fcs;      // FCS slot, data comes from the CRC
        logic       last;     // final FCS slot
        logic [1:0] fcs_idx;
    } seq_beat_t;

    // Sequencer FSM states
    typedef enum logic [2:0] {
        IDLE,
        PREAMBLE,
        SFD,
        DST_MAC,
        SRC_MAC,
        ETHERTYPE,
        PAYLOAD,
        FCS
    } seq_state_t;

    // Ethernet CRC-32, reflected form
    localparam crc_t CRC_INIT      = 32'hFFFF_FFFF;
    localparam crc_t CRC_POLY_REFL = 32'hEDB8_8320;

endpackage

// File: logic/frame_sequencer.sv
// Frame FSM that captures the configuration and emits one header, payload or FCS-slot beat per clock
`timescale 1ns/1ps

module frame_sequencer import eth_pkg::*; #(
    parameter int PREAMBLE_BYTES = 7
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       enable_r,
    input  frame_cfg_t cfg,
    output seq_beat_t  beat
);

    localparam len_t PRE_LAST = len_t'(PREAMBLE_BYTES - 1);

    seq_state_t state;
    seq_state_t state_nxt;
    len_t       cnt;
    len_t       cnt_nxt;
    seq_beat_t  beat_nxt;
    frame_cfg_t frame_r;

    // Byte idx of a MAC address, high byte first
    function automatic byte_t mac_byte(input mac_addr_t mac, input logic [2:0] idx);
        return mac[8 * (5 - idx) +: 8];
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Next state and next beat
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        state_nxt = state;
        cnt_nxt   = cnt;
        beat_nxt  = '0;

        // Low enable pauses the frame where it is
        if (enable_r) begin
            case (state)
                IDLE: begin
                    state_nxt = PREAMBLE;
                    cnt_nxt   = '0;
                end

                PREAMBLE: begin
                    beat_nxt.valid = 1'b1;
                    beat_nxt.data  = 8'h55;
                    if (cnt == PRE_LAST) begin
                        state_nxt = SFD;
                        cnt_nxt   = '0;
                    end else begin
                        cnt_nxt = cnt + 1'b1;
                    end
                end

                SFD: begin
                    beat_nxt.valid = 1'b1;
                    beat_nxt.data  = 8'hD5;
                    state_nxt      = DST_MAC;
                end

                DST_MAC: begin
                    beat_nxt.valid  = 1'b1;
                    beat_nxt.crc_en = 1'b1;
                    beat_nxt.data   = mac_byte(frame_r.dst_mac, cnt[2:0]);
                    if (cnt == len_t'(5)) begin
                        state_nxt = SRC_MAC;
                        cnt_nxt   = '0;
                    end else begin
                        cnt_nxt = cnt + 1'b1;
                    end
                end

                SRC_MAC: begin
                    beat_nxt.valid  = 1'b1;
                    beat_nxt.crc_en = 1'b1;
                    beat_nxt.data   = mac_byte(frame_r.src_mac, cnt[2:0]);
                    if (cnt == len_t'(5)) begin
                        state_nxt = ETHERTYPE;
                        cnt_nxt   = '0;
                    end else begin
                        cnt_nxt = cnt + 1'b1;
                    end
                end

                ETHERTYPE: begin
                    beat_nxt.valid  = 1'b1;
                    beat_nxt.crc_en = 1'b1;
                    beat_nxt.data   = cnt[0] ? frame_r.ethertype[7:0]
                                             : frame_r.ethertype[15:8];
                    if (cnt[0]) begin
                        cnt_nxt = '0;
                        // Empty payload goes straight to the FCS
                        if (frame_r.payload_length == '0) begin
                            state_nxt = FCS;
                        end else begin
                            state_nxt = PAYLOAD;
                        end
                    end else begin
                        cnt_nxt = cnt + 1'b1;
                    end
                end

                PAYLOAD: begin
                    beat_nxt.valid  = 1'b1;
                    beat_nxt.crc_en = 1'b1;
                    // Counting pattern, wraps mod 256
                    beat_nxt.data   = frame_r.payload_pattern + cnt[7:0];
                    if (cnt == frame_r.payload_length - 1'b1) begin
                        state_nxt = FCS;
                        cnt_nxt   = '0;
                    end else begin
                        cnt_nxt = cnt + 1'b1;
                    end
                end

                FCS: begin
                    beat_nxt.valid   = 1'b1;
                    beat_nxt.fcs     = 1'b1;
                    beat_nxt.fcs_idx = cnt[1:0];
                    if (cnt[1:0] == 2'd3) begin
                        beat_nxt.last = 1'b1;
                        state_nxt     = IDLE;
                        cnt_nxt       = '0;
                    end else begin
                        cnt_nxt = cnt + 1'b1;
                    end
                end

                default: begin
                    state_nxt = IDLE;
                    cnt_nxt   = '0;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= IDLE;
            cnt   <= '0;
            beat  <= '0;
        end else begin
            state <= state_nxt;
            cnt   <= cnt_nxt;
            beat  <= beat_nxt;
        end
    end

    // Config is frozen for the whole frame
    always_ff @(posedge clk) begin
        if (state == IDLE && enable_r) begin
            frame_r <= cfg;
        end
    end

    a_no_crc_in_fcs: assert property (
        @(posedge clk) disable iff (reset)
        beat.valid |-> !(beat.crc_en && beat.fcs)
    );

endmodule

// File: logic/crc32_engine.sv
// Byte-wide Ethernet CRC-32 accumulator fed by the sequencer beats, restarted every frame
`timescale 1ns/1ps

module crc32_engine import eth_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  seq_beat_t beat,
    output crc_t      crc
);

    logic restart;
    crc_t crc_folded;

    // One byte, LSB first, reflected polynomial
    function automatic crc_t crc_byte(input crc_t c_in, input byte_t d);
        crc_t c;
        c = c_in ^ {24'h0, d};
        for (int i = 0; i < 8; i++) begin
            if (c[0]) begin
                c = (c >> 1) ^ CRC_POLY_REFL;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Accumulator
    ////////////////////////////////////////////////////////////////////////////

    // Preamble and delimiter beats; the delimiter is the last load before the header
    assign restart    = beat.valid && !beat.crc_en && !beat.fcs;
    assign crc_folded = crc_byte(crc, beat.data);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            crc <= CRC_INIT;
        end else if (restart) begin
            crc <= CRC_INIT;
        end else if (beat.valid && beat.crc_en) begin
            crc <= crc_folded;
        end
    end

    // Unknown bytes would poison the rest of the frame
    a_known_crc_data: assert property (
        @(posedge clk) disable iff (reset)
        beat.valid && beat.crc_en |-> !$isunknown(beat.data)
    );

endmodule

// File: logic/fcs_inserter.sv
// Output stage that puts the complemented CRC into the FCS slots and drives the transmit stream
`timescale 1ns/1ps

module fcs_inserter import eth_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  seq_beat_t beat,
    input  crc_t      crc,
    output byte_t     tx_data,
    output logic      tx_valid,
    output logic      tx_done
);

    crc_t  fcs_word;
    byte_t fcs_byte;
    byte_t out_byte;

    ////////////////////////////////////////////////////////////////////////////
    // Byte select
    ////////////////////////////////////////////////////////////////////////////

    // FCS goes out complemented, lowest byte first
    assign fcs_word = ~crc;
    assign fcs_byte = fcs_word[8 * beat.fcs_idx +: 8];
    assign out_byte = beat.fcs ? fcs_byte : beat.data;

    ////////////////////////////////////////////////////////////////////////////
    // Output register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tx_data  <= '0;
            tx_valid <= 1'b0;
            tx_done  <= 1'b0;
        end else begin
            tx_valid <= beat.valid;
            tx_done  <= beat.last;
            // Data holds between beats
            if (beat.valid) begin
                tx_data <= out_byte;
            end
        end
    end

    a_done_with_valid: assert property (
        @(posedge clk) disable iff (reset)
        tx_done |-> tx_valid
    );

endmodule

// File: logic/eth_frame_gen.sv
// Top level of the Ethernet test frame generator; registers the inputs and wires the pipeline
`timescale 1ns/1ps

module eth_frame_gen import eth_pkg::*; #(
    parameter int PREAMBLE_BYTES = 7
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       enable,
    input  mac_addr_t  src_mac,
    input  mac_addr_t  dst_mac,
    input  ethertype_t ethertype,
    input  byte_t      payload_pattern,
    input  len_t       payload_length,
    output byte_t      tx_data,
    output logic       tx_valid,
    output logic       tx_done
);

    logic       enable_r;
    frame_cfg_t cfg_r;
    seq_beat_t  beat;
    crc_t       crc;

    ////////////////////////////////////////////////////////////////////////////
    // Input register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            enable_r <= 1'b0;
            cfg_r    <= '0;
        end else begin
            enable_r              <= enable;
            cfg_r.dst_mac         <= dst_mac;
            cfg_r.src_mac         <= src_mac;
            cfg_r.ethertype       <= ethertype;
            cfg_r.payload_pattern <= payload_pattern;
            cfg_r.payload_length  <= payload_length;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Pipeline
    ////////////////////////////////////////////////////////////////////////////

    frame_sequencer #(
        .PREAMBLE_BYTES (PREAMBLE_BYTES)
    ) u_seq (
        .clk      (clk),
        .reset    (reset),
        .enable_r (enable_r),
        .cfg      (cfg_r),
        .beat     (beat)
    );

    // Runs beside the sequencer, one beat behind
    crc32_engine u_crc (
        .clk   (clk),
        .reset (reset),
        .beat  (beat),
        .crc   (crc)
    );

    fcs_inserter u_fcs (
        .clk      (clk),
        .reset    (reset),
        .beat     (beat),
        .crc      (crc),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .tx_done  (tx_done)
    );

endmodule

// File: tests/frame_model.svh
// Reference model for the frame generator testbench; included inside the testbench module
`ifndef FRAME_MODEL_SVH
`define FRAME_MODEL_SVH

// Ethernet CRC-32, one bit at a time, LSB first
function automatic crc_t calc_crc(input byte_t bytes[$]);
    crc_t c;
    logic fb;
    c = CRC_INIT;
    foreach (bytes[i]) begin
        for (int b = 0; b < 8; b++) begin
            fb = c[0] ^ bytes[i][b];
            c  = c >> 1;
            if (fb) begin
                c = c ^ CRC_POLY_REFL;
            end
        end
    end
    return c;
endfunction

// Bytes on the wire for one configuration, preamble through FCS
function automatic void build_frame(input frame_cfg_t cfg, output byte_t q[$]);
    byte_t body[$];
    crc_t  fcs;
    q = {};
    for (int i = 0; i < 6; i++) body.push_back(cfg.dst_mac[8 * (5 - i) +: 8]);
    for (int i = 0; i < 6; i++) body.push_back(cfg.src_mac[8 * (5 - i) +: 8]);
    body.push_back(cfg.ethertype[15:8]);
    body.push_back(cfg.ethertype[7:0]);
    // Counting pattern, wraps mod 256
    for (int i = 0; i < int'(cfg.payload_length); i++) begin
        body.push_back(cfg.payload_pattern + byte_t'(i));
    end
    fcs = ~calc_crc(body);
    for (int i = 0; i < PREAMBLE_BYTES; i++) q.push_back(8'h55);
    q.push_back(8'hD5);
    foreach (body[i]) q.push_back(body[i]);
    for (int i = 0; i < 4; i++) q.push_back(fcs[8 * i +: 8]);
endfunction

// Preamble, delimiter, header, payload and FCS
function automatic int frame_len(input len_t len);
    return PREAMBLE_BYTES + 1 + 14 + int'(len) + 4;
endfunction

`endif

// File: tests/tb_eth_frame_gen.sv
// Directed testbench for the Ethernet frame generator; compile with the project file list
`timescale 1ns/1ps

module tb_eth_frame_gen import eth_pkg::*; ();

    localparam int PREAMBLE_BYTES = 7;
    // 15 frames, payloads summed with random ones at their 127-byte maximum
    localparam int MAX_CYCLES = 2 * (15 * (PREAMBLE_BYTES + 19) + 1454) + 500;

    logic       clk;
    logic       reset;
    logic       enable;
    mac_addr_t  src_mac;
    mac_addr_t  dst_mac;
    ethertype_t ethertype;
    byte_t      payload_pattern;
    len_t       payload_length;
    byte_t      tx_data;
    logic       tx_valid;
    logic       tx_done;

    int          cyc = 0;
    int          errors;
    int          checks;
    logic [31:0] rng;
    byte_t       got_q[$];
    int          got_cyc[$];
    int          done_cyc[$];
    frame_cfg_t  cfg_list[$];

    `include "frame_model.svh"

    eth_frame_gen #(
        .PREAMBLE_BYTES (PREAMBLE_BYTES)
    ) uut (
        .clk             (clk),
        .reset           (reset),
        .enable          (enable),
        .src_mac         (src_mac),
        .dst_mac         (dst_mac),
        .ethertype       (ethertype),
        .payload_pattern (payload_pattern),
        .payload_length  (payload_length),
        .tx_data         (tx_data),
        .tx_valid        (tx_valid),
        .tx_done         (tx_done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    // Outputs sampled mid-cycle
    always @(negedge clk) begin
        if (!reset && tx_valid) begin
            got_q.push_back(tx_data);
            got_cyc.push_back(cyc);
        end
        if (!reset && tx_done) done_cyc.push_back(cyc);
    end

    initial begin
        while (cyc <= MAX_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles, %0d errors so far", MAX_CYCLES, errors);
        $display("Errors found");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("mismatch %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic report_failure(input string text);
        errors++;
        $display("%s", text);
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic frame_cfg_t make_cfg(input mac_addr_t dst, input mac_addr_t src,
                                            input ethertype_t etype, input byte_t pattern,
                                            input len_t len);
        frame_cfg_t c;
        c.dst_mac         = dst;
        c.src_mac         = src;
        c.ethertype       = etype;
        c.payload_pattern = pattern;
        c.payload_length  = len;
        return c;
    endfunction

    task automatic apply_cfg(input frame_cfg_t c);
        dst_mac         = c.dst_mac;
        src_mac         = c.src_mac;
        ethertype       = c.ethertype;
        payload_pattern = c.payload_pattern;
        payload_length  = c.payload_length;
    endtask

    task automatic add_random_cfg();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        rng = xorshift(rng);
        a   = rng;
        rng = xorshift(rng);
        b   = rng;
        rng = xorshift(rng);
        c   = rng;
        rng = xorshift(rng);
        d   = rng;
        cfg_list.push_back(make_cfg({a, b[15:0]}, {b[31:16], c}, d[15:0], d[23:16],
                                    len_t'(d[30:24])));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_reset_state();
        repeat (5) begin
            @(posedge clk);
            #1;
            check("reset", 0, tx_valid);
            check("reset", 0, tx_done);
            check("reset", 0, tx_data);
        end
        reset = 1'b0;
        repeat (2) begin
            @(negedge clk);
            check("after reset", 0, tx_valid);
            check("after reset", 0, tx_done);
            check("after reset", 0, tx_data);
        end
    endtask

    // Sends cfg_list back to back; the first frame can pause mid-frame.
    // The next config is applied halfway through the current frame.
    task automatic send_frames(input string name, input int pause_at, input int pause_len);
        byte_t exp_q[$];
        byte_t fq[$];
        int    ends[$];
        int    start;
        int    pause_cyc;
        int    n;
        int    waited;
        int    exp_end;
        got_q     = {};
        got_cyc   = {};
        done_cyc  = {};
        pause_cyc = -100;
        foreach (cfg_list[k]) begin
            build_frame(cfg_list[k], fq);
            foreach (fq[i]) exp_q.push_back(fq[i]);
            ends.push_back(exp_q.size() - 1);
        end
        @(posedge clk);
        #1;
        apply_cfg(cfg_list[0]);
        enable = 1'b1;
        start  = cyc;
        foreach (cfg_list[k]) begin
            n = frame_len(cfg_list[k].payload_length);
            repeat (3) @(posedge clk);
            #1;
            for (int i = 0; i < n - 2; i++) begin
                if (k + 1 < cfg_list.size() && i == (n - 2) / 2) apply_cfg(cfg_list[k + 1]);
                if (k == 0 && pause_len > 0 && i == pause_at) begin
                    pause_cyc = cyc;
                    enable    = 1'b0;
                    repeat (pause_len) @(posedge clk);
                    #1;
                    enable = 1'b1;
                end
                @(posedge clk);
                #1;
            end
        end
        // Low just before the last FCS beat so no further frame starts
        enable = 1'b0;
        waited = 0;
        while (done_cyc.size() < cfg_list.size() && waited < 64) begin
            @(posedge clk);
            waited++;
        end
        repeat (4) @(posedge clk);

        if (done_cyc.size() != cfg_list.size()) begin
            report_failure($sformatf("%s: expected %0d tx_done pulses, saw %0d", name,
                                     cfg_list.size(), done_cyc.size()));
        end
        if (got_q.size() < exp_q.size()) begin
            report_failure($sformatf("%s: frame ended early, %0d of %0d bytes received",
                                     name, got_q.size(), exp_q.size()));
        end else if (got_q.size() > exp_q.size()) begin
            report_failure($sformatf("%s: %0d bytes received, only %0d expected",
                                     name, got_q.size(), exp_q.size()));
        end else if (got_q.size() > 0) begin
            check(name, exp_q.size() - 1 + cfg_list.size() - 1 + pause_len,
                  got_cyc[got_cyc.size() - 1] - got_cyc[0]);
        end
        for (int i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
            check(name, exp_q[i], got_q[i]);
        end
        if (got_cyc.size() > 0) check(name, start + 4, got_cyc[0]);
        // Last byte and tx_done of each frame, one idle cycle between frames
        foreach (ends[k]) begin
            exp_end = start + 4 + ends[k] + k + pause_len;
            if (ends[k] < got_cyc.size()) begin
                check(name, exp_end, got_cyc[ends[k]]);
            end
            if (k < done_cyc.size()) begin
                check(name, exp_end, done_cyc[k]);
            end
        end
        foreach (got_cyc[i]) begin
            if (got_cyc[i] >= pause_cyc + 3 && got_cyc[i] <= pause_cyc + 2 + pause_len) begin
                report_failure($sformatf("%s: tx_valid high during the enable pause at cycle %0d",
                                         name, got_cyc[i]));
            end
        end
    endtask

    initial begin
        errors          = 0;
        checks          = 0;
        rng             = 32'hc9ed_fe3f;
        reset           = 1'b1;
        enable          = 1'b0;
        src_mac         = '0;
        dst_mac         = '0;
        ethertype       = '0;
        payload_pattern = '0;
        payload_length  = '0;

        check_reset_state();

        cfg_list = {};
        cfg_list.push_back(make_cfg(48'h0011_2233_4455, 48'h0266_7788_99AA, 16'h0800,
                                    8'h10, 11'd46));
        send_frames("basic", 0, 0);

        cfg_list = {};
        cfg_list.push_back(make_cfg(48'h0011_2233_4455, 48'h0266_7788_99AA, 16'h0800,
                                    8'hF0, 11'd0));
        cfg_list.push_back(make_cfg(48'h0011_2233_4455, 48'h0266_7788_99AA, 16'h0800,
                                    8'hF0, 11'd1));
        cfg_list.push_back(make_cfg(48'h0011_2233_4455, 48'h0266_7788_99AA, 16'h0800,
                                    8'hF0, 11'd255));
        send_frames("edge lengths", 0, 0);

        // Pause lands in the payload
        cfg_list = {};
        cfg_list.push_back(make_cfg(48'h0011_2233_4455, 48'h0266_7788_99AA, 16'h0800,
                                    8'h10, 11'd46));
        send_frames("enable pause", 24, 6);

        cfg_list = {};
        cfg_list.push_back(make_cfg(48'h0200_0000_00AA, 48'h0200_0000_0011, 16'h88B5,
                                    8'h00, 11'd60));
        cfg_list.push_back(make_cfg(48'h0600_1111_2222, 48'h0A00_3333_4444, 16'h88B5,
                                    8'h80, 11'd30));
        send_frames("config isolation", 0, 0);

        cfg_list = {};
        repeat (8) add_random_cfg();
        send_frames("random back to back", 0, 0);

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+tests
logic/eth_pkg.sv
logic/frame_sequencer.sv
logic/crc32_engine.sv
logic/fcs_inserter.sv
logic/eth_frame_gen.sv
tests/tb_eth_frame_gen.sv
